//--- filelist.f
logic/conv_window_pkg.sv
logic/window_ctrl_fsm.sv
logic/scan_counters.sv
logic/line_buffer_ram.sv
logic/window_register.sv
logic/conv_window_top.sv
verif/conv_window_assertions.sv
verif/window_checker.sv
verif/tb_conv_window.sv

//--- Makefile
SIM_LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_conv_window -f filelist.f
	./obj_dir/Vtb_conv_window > $(SIM_LOG) 2>&1 || true
	@cat $(SIM_LOG)
	@if grep -q "Simulation failed" $(SIM_LOG) || ! grep -q "Simulation passed" $(SIM_LOG); then \
		echo "Result: FAIL"; exit 1; \
	else \
		echo "Result: PASS"; \
	fi

clean:
	rm -rf obj_dir $(SIM_LOG)

//--- verif/window_input.txt
// offset stall_pct gap_pct window_count center_sum, all hex
// One frame per line, rates are percentages of low cycles
00 00 00 310 1b5b0
10 1e 14 310 1c2b0
03 3c 32 310 1b8e0
00 0a 46 310 1b5b0

//--- verif/tb_conv_window.sv
// Convolution window generator testbench
`timescale 1ns/1ns
`default_nettype none

module tb_conv_window;

    localparam int max_tests     = 16;
    localparam int fields        = 5;   // Words per stimulus line
    localparam int window_cycles = 20;  // Per window, leaves room for stalls and gaps

    logic                     clk = 1'b0;
    logic                     reset_n;
    logic                     i_start;
    logic                     i_pixel_valid;
    conv_window_pkg::pixel_t  i_pixel;
    logic                     i_conv_ready;
    logic                     o_fill_active;
    conv_window_pkg::window_t o_window;
    logic                     o_conv_valid;
    logic                     o_conv_row_start;
    logic                     o_conv_row_end;
    logic                     o_done;

    logic [31:0] test_data [max_tests*fields];
    logic [7:0]  offset;
    logic [31:0] exp_windows;
    logic [31:0] exp_sum;
    int          stall_pct;
    int          gap_pct;
    int          num_tests = 0;
    int          pix_idx = 0;
    int          seed = 32'heee1;
    int          errors;
    int          tests_done;
    int          tests_failed;

    always #5 clk = ~clk;

    conv_window_top dut (.*);

    window_checker u_checker (
        .clk            (clk),
        .reset_n        (reset_n),
        .i_start        (i_start),
        .i_pixel_valid  (i_pixel_valid),
        .i_conv_ready   (i_conv_ready),
        .i_fill_active  (o_fill_active),
        .i_window       (o_window),
        .i_conv_valid   (o_conv_valid),
        .i_row_start    (o_conv_row_start),
        .i_row_end      (o_conv_row_end),
        .i_done         (o_done),
        .i_offset       (offset),
        .i_exp_windows  (exp_windows),
        .i_exp_sum      (exp_sum),
        .o_errors       (errors),
        .o_tests_done   (tests_done),
        .o_tests_failed (tests_failed)
    );

    bind conv_window_top conv_window_assertions u_assertions (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_pix_we      (pix_we),
        .i_wr_line     (wr_line),
        .i_rd_base     (rd_base),
        .i_col_step    (col_step),
        .i_win_col     (win_col),
        .i_frame_clear (frame_clear),
        .i_load_done   (load_done),
        .i_done        (o_done)
    );

    // Raster-order pixels, each held until the DUT takes it
    always @(posedge clk) begin
        int roll;

        if (i_start) begin
            pix_idx = 0;
        end else if (i_pixel_valid && o_fill_active) begin
            pix_idx = pix_idx + 1;
        end
        i_pixel <= 8'((pix_idx / conv_window_pkg::img_size) * 7 +
                      (pix_idx % conv_window_pkg::img_size) * 3 + offset);
        roll = $unsigned($random(seed)) % 100;
        i_pixel_valid <= (roll >= gap_pct);
        roll = $unsigned($random(seed)) % 100;
        i_conv_ready <= (roll >= stall_pct);  // Ready low at the stall rate
    end

    initial begin
        int t;

        reset_n = 1'b0;
        i_start = 1'b0;
        i_pixel_valid = 1'b0;
        i_pixel = '0;
        i_conv_ready = 1'b0;
        offset = '0;
        exp_windows = '0;
        exp_sum = '0;
        stall_pct = 0;
        gap_pct = 0;
        for (int a = 0; a < max_tests * fields; a++) test_data[a] = '1;
        $readmemh("verif/window_input.txt", test_data);
        while (num_tests < max_tests && test_data[num_tests * fields] !== '1) num_tests++;
        repeat (16) @(posedge clk);
        reset_n <= 1'b1;
        @(posedge clk);
        for (t = 0; t < num_tests; t++) begin
            @(posedge clk);
            offset      <= test_data[t * fields][7:0];
            stall_pct   <= test_data[t * fields + 1];
            gap_pct     <= test_data[t * fields + 2];
            exp_windows <= test_data[t * fields + 3];
            exp_sum     <= test_data[t * fields + 4];
            i_start     <= 1'b1;
            @(posedge clk);
            i_start <= 1'b0;
            while (tests_done < t + 1) @(posedge clk);  // Checker saw o_done
        end
        repeat (4) @(posedge clk);
        $display("Tests run %0d of %0d, failed %0d, errors %0d",
                 tests_done, num_tests, tests_failed, errors);
        if (num_tests > 0 && tests_done == num_tests && tests_failed == 0 && errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog sized from the number of frames in the file
    initial begin
        wait (num_tests > 0);
        #(num_tests * conv_window_pkg::out_size * conv_window_pkg::out_size * window_cycles * 10
          + 1000);
        $display("Watchdog expired at %0t before all frames finished", $time);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/window_checker.sv
// Window output checker
`timescale 1ns/1ns
`default_nettype none

module window_checker (
    input  wire                       clk,
    input  wire                       reset_n,
    input  wire                       i_start,
    input  wire                       i_pixel_valid,
    input  wire                       i_conv_ready,
    input  wire                       i_fill_active,
    input  conv_window_pkg::window_t  i_window,
    input  wire                       i_conv_valid,
    input  wire                       i_row_start,
    input  wire                       i_row_end,
    input  wire                       i_done,
    input  wire  [7:0]                i_offset,
    input  wire  [31:0]               i_exp_windows,
    input  wire  [31:0]               i_exp_sum,
    output int                        o_errors,
    output int                        o_tests_done,
    output int                        o_tests_failed
);

    localparam int n_out = conv_window_pkg::out_size;

    logic        started;
    logic        in_frame;
    logic        ready_q;     // Ready as seen on the previous edge
    logic [31:0] center_sum;
    int          win_cnt;
    int          pix_cnt;
    int          start_cnt;
    int          end_cnt;
    int          frame_errs;
    int          err_total;
    int          done_total;
    int          failed_total;

    // Image rule of the test pattern
    function automatic logic signed [7:0] image_pixel(input logic [7:0] offs, input int r,
                                                      input int c);
        return 8'(r * 7 + c * 3 + offs);
    endfunction

    task automatic flag_mismatch(input string name, input int expected, input int actual);
        $display("CHECK FAILED at %0t: %s expected %0d got %0d", $time, name, expected, actual);
        err_total++;
        frame_errs++;
    endtask

    task automatic flag_problem(input string what);
        $display("ERROR at %0t: %s", $time, what);
        err_total++;
        frame_errs++;
    endtask

    always @(posedge clk) begin
        int                row;
        int                col;
        logic signed [7:0] exp_px;

        if (!reset_n) begin
            started = 1'b0;
            in_frame = 1'b0;
            ready_q = 1'b0;
            err_total = 0;
            done_total = 0;
            failed_total = 0;
        end else begin
            if (i_start) begin  // Frame starts on this edge
                started = 1'b1;
                in_frame = 1'b1;
                win_cnt = 0;
                pix_cnt = 0;
                start_cnt = 0;
                end_cnt = 0;
                center_sum = '0;
                frame_errs = 0;
            end
            if (!started && (i_fill_active || i_conv_valid || i_row_start || i_row_end || i_done))
                flag_problem("control output high before the first start");
            if (i_pixel_valid && i_fill_active) pix_cnt++;
            if (i_conv_valid) begin
                if (!ready_q) flag_problem("window without ready on the previous edge");
                if (!in_frame || win_cnt >= n_out * n_out) begin
                    flag_problem("window outside a frame");
                end else begin
                    row = win_cnt / n_out;
                    col = win_cnt % n_out;
                    for (int i = 0; i < conv_window_pkg::kernel_size; i++) begin
                        for (int j = 0; j < conv_window_pkg::kernel_size; j++) begin
                            exp_px = image_pixel(i_offset, row + i, col + j);
                            if (i_window[i][j] !== exp_px)
                                flag_mismatch($sformatf("o_window[%0d][%0d] of window %0d",
                                              i, j, win_cnt), exp_px, i_window[i][j]);
                        end
                    end
                    if (i_row_start !== (col == 0))
                        flag_mismatch("o_conv_row_start", col == 0, i_row_start);
                    if (i_row_end !== (col == n_out - 1))
                        flag_mismatch("o_conv_row_end", col == n_out - 1, i_row_end);
                    center_sum = center_sum + {24'd0, i_window[2][2]};
                    win_cnt++;
                end
            end else if (i_row_start || i_row_end) begin
                flag_problem("row marker without a window");
            end
            start_cnt += i_row_start;
            end_cnt += i_row_end;
            if (i_done && !in_frame) begin
                flag_problem("o_done outside a frame");
            end else if (i_done) begin
                if (win_cnt != i_exp_windows) flag_mismatch("window count", i_exp_windows, win_cnt);
                if (center_sum != i_exp_sum) flag_mismatch("center sum", i_exp_sum, center_sum);
                if (pix_cnt != 1024) flag_mismatch("accepted pixels", 1024, pix_cnt);
                if (start_cnt != n_out) flag_mismatch("o_conv_row_start count", n_out, start_cnt);
                if (end_cnt != n_out) flag_mismatch("o_conv_row_end count", n_out, end_cnt);
                in_frame = 1'b0;
                done_total++;
                if (frame_errs != 0) failed_total++;
                $display("Test %0d offset %0d: %0d windows, %0d pixels, center sum %0d, %s",
                         done_total, i_offset, win_cnt, pix_cnt, center_sum,
                         (frame_errs == 0) ? "ok" : "with errors");
            end
            ready_q = i_conv_ready;
        end
        o_errors <= err_total;
        o_tests_done <= done_total;
        o_tests_failed <= failed_total;
    end

endmodule

`default_nettype wire

//--- verif/conv_window_assertions.sv
// Line buffer and control assertions
`timescale 1ns/1ns
`default_nettype none

module conv_window_assertions (
    input wire                                clk,
    input wire                                reset_n,
    input wire                                i_pix_we,
    input wire [conv_window_pkg::line_w-1:0]  i_wr_line,
    input wire [conv_window_pkg::line_w-1:0]  i_rd_base,
    input wire                                i_col_step,
    input wire [conv_window_pkg::col_w-1:0]   i_win_col,
    input wire                                i_frame_clear,
    input wire                                i_load_done,
    input wire                                i_done
);

    logic                               loading;     // Start until five rows are filled
    logic                               convolving;  // From the first window step on
    logic [conv_window_pkg::line_w-1:0] spare_line;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            loading    <= 1'b0;
            convolving <= 1'b0;
        end else if (i_frame_clear) begin
            loading    <= 1'b1;
            convolving <= 1'b0;
        end else begin
            if (i_load_done) loading <= 1'b0;
            if (i_col_step) convolving <= 1'b1;
        end
    end

    // Line just behind the read base, outside the five read lines
    assign spare_line = (i_rd_base == '0) ?
                        3'(conv_window_pkg::num_lines - 1) : i_rd_base - 1'b1;

    spare_write: assert property (@(posedge clk) disable iff (!reset_n)
        (convolving && i_pix_we) |-> (i_wr_line == spare_line))
        else $error("Pixel write into a line that is being read");

    done_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        i_done |=> !i_done)
        else $error("o_done high for more than one cycle");

    col_range: assert property (@(posedge clk) disable iff (!reset_n)
        i_win_col <= 5'(conv_window_pkg::out_size - 1))
        else $error("Window column beyond the last valid column");

    no_step_in_load: assert property (@(posedge clk) disable iff (!reset_n)
        !(loading && i_col_step))
        else $error("Window step during the initial load");

endmodule

`default_nettype wire

//--- logic/conv_window_top.sv
// 5x5 convolution window generator
`timescale 1ns/1ns
`default_nettype none

module conv_window_top (
    input  wire                         clk,
    input  wire                         reset_n,
    input  wire                         i_start,
    input  wire                         i_pixel_valid,
    input  conv_window_pkg::pixel_t     i_pixel,
    input  wire                         i_conv_ready,
    output logic                        o_fill_active,
    output conv_window_pkg::window_t    o_window,
    output logic                        o_conv_valid,
    output logic                        o_conv_row_start,
    output logic                        o_conv_row_end,
    output logic                        o_done
);

    logic                               pix_we;
    logic                               col_step;
    logic                               row_step;
    logic                               frame_clear;
    logic                               row_filled;
    logic                               load_done;
    logic                               rows_remain;
    logic                               col_first;
    logic                               col_last;
    logic                               row_last;
    logic [conv_window_pkg::line_w-1:0] wr_line;
    logic [conv_window_pkg::line_w-1:0] rd_base;
    logic [conv_window_pkg::col_w-1:0]  wr_col;
    logic [conv_window_pkg::col_w-1:0]  win_col;
    conv_window_pkg::block_t            block;

    window_ctrl_fsm u_fsm (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_start       (i_start),
        .i_pixel_valid (i_pixel_valid),
        .i_conv_ready  (i_conv_ready),
        .i_row_filled  (row_filled),
        .i_load_done   (load_done),
        .i_rows_remain (rows_remain),
        .i_col_last    (col_last),
        .i_row_last    (row_last),
        .o_fill_active (o_fill_active),
        .o_pix_we      (pix_we),
        .o_col_step    (col_step),
        .o_row_step    (row_step),
        .o_frame_clear (frame_clear),
        .o_done        (o_done)
    );

    scan_counters u_cnt (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_frame_clear (frame_clear),
        .i_pix_we      (pix_we),
        .i_col_step    (col_step),
        .i_row_step    (row_step),
        .o_wr_line     (wr_line),
        .o_wr_col      (wr_col),
        .o_win_col     (win_col),
        .o_rd_base     (rd_base),
        .o_row_filled  (row_filled),
        .o_load_done   (load_done),
        .o_rows_remain (rows_remain),
        .o_col_first   (col_first),
        .o_col_last    (col_last),
        .o_row_last    (row_last)
    );

    line_buffer_ram u_ram (
        .clk        (clk),
        .i_we       (pix_we),
        .i_wr_line  (wr_line),
        .i_wr_col   (wr_col),
        .i_wr_pixel (i_pixel),
        .i_win_col  (win_col),
        .o_block    (block)
    );

    window_register u_win (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_block     (block),
        .i_rd_base   (rd_base),
        .i_capture   (col_step),
        .i_first     (col_first),
        .i_last      (col_last),
        .o_window    (o_window),
        .o_valid     (o_conv_valid),
        .o_row_start (o_conv_row_start),
        .o_row_end   (o_conv_row_end)
    );

endmodule

`default_nettype wire

//--- logic/window_register.sv
// Window row select and output register
`timescale 1ns/1ns
`default_nettype none

module window_register (
    input  wire                                 clk,
    input  wire                                 reset_n,
    input  conv_window_pkg::block_t             i_block,
    input  wire  [conv_window_pkg::line_w-1:0]  i_rd_base,
    input  wire                                 i_capture,
    input  wire                                 i_first,
    input  wire                                 i_last,
    output conv_window_pkg::window_t            o_window,
    output logic                                o_valid,
    output logic                                o_row_start,
    output logic                                o_row_end
);

    conv_window_pkg::window_t window_nxt;

    always_comb begin
        logic [conv_window_pkg::line_w:0] slot;  // One spare bit for the wrap

        slot = '0;
        for (int r = 0; r < conv_window_pkg::kernel_size; r++) begin
            slot = {1'b0, i_rd_base} + r[conv_window_pkg::line_w:0];
            if (slot >= conv_window_pkg::num_lines) begin
                slot = slot - conv_window_pkg::num_lines[conv_window_pkg::line_w:0];
            end
            for (int k = 0; k < conv_window_pkg::kernel_size; k++) begin
                window_nxt[r][k] = $signed(i_block[slot[conv_window_pkg::line_w-1:0]][k]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_capture) o_window <= window_nxt;
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            o_valid     <= 1'b0;
            o_row_start <= 1'b0;
            o_row_end   <= 1'b0;
        end else begin
            o_valid     <= i_capture;
            o_row_start <= i_capture && i_first;  // Aligned with the first window
            o_row_end   <= i_capture && i_last;
        end
    end

endmodule

`default_nettype wire

//--- logic/line_buffer_ram.sv
// Six-line circular pixel buffer
`timescale 1ns/1ns
`default_nettype none

module line_buffer_ram (
    input  wire                                 clk,
    input  wire                                 i_we,
    input  wire  [conv_window_pkg::line_w-1:0]  i_wr_line,
    input  wire  [conv_window_pkg::col_w-1:0]   i_wr_col,
    input  conv_window_pkg::pixel_t             i_wr_pixel,
    input  wire  [conv_window_pkg::col_w-1:0]   i_win_col,
    output conv_window_pkg::block_t             o_block
);

    conv_window_pkg::pixel_t mem [conv_window_pkg::num_lines][conv_window_pkg::img_size];

    // Single write port, one pixel per accepted edge
    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_wr_line][i_wr_col] <= i_wr_pixel;
        end
    end

    // Five neighbouring pixels from every line, window row order sorted out later
    always_comb begin
        logic [conv_window_pkg::col_w-1:0] rd_col;

        rd_col = '0;
        for (int l = 0; l < conv_window_pkg::num_lines; l++) begin
            for (int k = 0; k < conv_window_pkg::kernel_size; k++) begin
                rd_col        = i_win_col + k[conv_window_pkg::col_w-1:0];  // At most 31
                o_block[l][k] = mem[l][rd_col];
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/scan_counters.sv
// Write and window scan counters
`timescale 1ns/1ns
`default_nettype none

module scan_counters (
    input  wire                                       clk,
    input  wire                                       reset_n,
    input  wire                                       i_frame_clear,
    input  wire                                       i_pix_we,
    input  wire                                       i_col_step,
    input  wire                                       i_row_step,
    output logic [conv_window_pkg::line_w-1:0]        o_wr_line,
    output logic [conv_window_pkg::col_w-1:0]         o_wr_col,
    output logic [conv_window_pkg::col_w-1:0]         o_win_col,
    output logic [conv_window_pkg::line_w-1:0]        o_rd_base,
    output logic                                      o_row_filled,
    output logic                                      o_load_done,
    output logic                                      o_rows_remain,
    output logic                                      o_col_first,
    output logic                                      o_col_last,
    output logic                                      o_row_last
);

    logic [conv_window_pkg::fill_row_w-1:0] filled_rows;  // Image rows fully written
    logic [conv_window_pkg::col_w-1:0]      out_row;

    // Write side
    always_ff @(posedge clk) begin
        if (!reset_n || i_frame_clear) begin
            o_wr_col    <= '0;
            o_wr_line   <= '0;
            filled_rows <= '0;
        end else if (i_pix_we) begin
            if (o_row_filled) begin
                o_wr_col    <= '0;
                o_wr_line   <= (o_wr_line == conv_window_pkg::num_lines - 1) ?
                               '0 : o_wr_line + 1'b1;
                filled_rows <= filled_rows + 1'b1;
            end else begin
                o_wr_col <= o_wr_col + 1'b1;
            end
        end
    end

    // Read side
    always_ff @(posedge clk) begin
        if (!reset_n || i_frame_clear) begin
            o_win_col <= '0;
            out_row   <= '0;
            o_rd_base <= '0;
        end else if (i_row_step) begin
            o_win_col <= '0;
            out_row   <= out_row + 1'b1;
            o_rd_base <= (o_rd_base == conv_window_pkg::num_lines - 1) ?
                         '0 : o_rd_base + 1'b1;
        end else if (i_col_step && !o_col_last) begin
            o_win_col <= o_win_col + 1'b1;  // Holds at the last column
        end
    end

    // Row completes on the write of its last column
    assign o_row_filled  = i_pix_we && (o_wr_col == conv_window_pkg::img_size - 1);
    assign o_load_done   = (filled_rows == conv_window_pkg::kernel_size);
    assign o_rows_remain = (filled_rows < conv_window_pkg::img_size);
    assign o_col_first   = (o_win_col == '0);
    assign o_col_last    = (o_win_col == conv_window_pkg::out_size - 1);
    assign o_row_last    = (out_row == conv_window_pkg::out_size - 1);

endmodule

`default_nettype wire

//--- logic/window_ctrl_fsm.sv
// Window generator control FSM
`timescale 1ns/1ns
`default_nettype none

module window_ctrl_fsm (
    input  wire  clk,
    input  wire  reset_n,
    input  wire  i_start,
    input  wire  i_pixel_valid,
    input  wire  i_conv_ready,
    input  wire  i_row_filled,
    input  wire  i_load_done,
    input  wire  i_rows_remain,
    input  wire  i_col_last,
    input  wire  i_row_last,
    output logic o_fill_active,
    output logic o_pix_we,
    output logic o_col_step,
    output logic o_row_step,
    output logic o_frame_clear,
    output logic o_done
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOAD,
        S_CONV,
        S_ROLL,
        S_FINISH
    } state_t;

    state_t state;
    state_t state_nxt;
    logic   fill_pending;  // Spare line still waiting for its row

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE:   if (i_start) state_nxt = S_LOAD;
            S_LOAD:   if (i_load_done) state_nxt = S_CONV;  // Rows 0 to 4 present
            S_CONV:   if (o_col_step && i_col_last) state_nxt = S_ROLL;
            S_ROLL: begin
                // Next output row needs the prefetched line
                if (!fill_pending) state_nxt = i_row_last ? S_FINISH : S_CONV;
            end
            S_FINISH: state_nxt = S_IDLE;
            default:  state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state        <= S_IDLE;
            fill_pending <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == S_LOAD && i_load_done) begin
                fill_pending <= 1'b1;  // Prefetch row 5 during output row 0
            end else if (o_row_step && i_rows_remain) begin
                fill_pending <= 1'b1;
            end else if (i_row_filled) begin
                fill_pending <= 1'b0;
            end
        end
    end

    assign o_fill_active = (state == S_LOAD && !i_load_done) || fill_pending;
    assign o_pix_we      = i_pixel_valid && o_fill_active;
    assign o_col_step    = (state == S_CONV) && i_conv_ready;  // One window per ready edge
    assign o_row_step    = (state == S_ROLL) && !fill_pending && !i_row_last;
    assign o_frame_clear = (state == S_IDLE) && i_start;
    assign o_done        = (state == S_FINISH);

endmodule

`default_nettype wire

//--- logic/conv_window_pkg.sv
// Convolution window shared definitions
`default_nettype none

package conv_window_pkg;

    localparam int img_size    = 32;  // Frame width and height
    localparam int kernel_size = 5;
    localparam int out_size    = img_size - kernel_size + 1;  // Valid windows per row
    localparam int num_lines   = 6;   // Five read lines plus one prefetch line

    localparam int pixel_w    = 8;
    localparam int col_w      = 5;
    localparam int fill_row_w = 6;    // Counts 0 to 32 filled rows
    localparam int line_w     = 3;

    typedef logic [pixel_w-1:0] pixel_t;
    typedef logic signed [pixel_w-1:0] spixel_t;

    // Window row i, column j at [i][j]
    typedef spixel_t [kernel_size-1:0][kernel_size-1:0] window_t;

    // Five pixels per physical line, indexed by line slot
    typedef pixel_t [num_lines-1:0][kernel_size-1:0] block_t;

endpackage

`default_nettype wire
